/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fetch_frontend
FLIST     ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@! grep -q '>>> FAIL' $(LOG)
	@grep -q '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* fetch_branch_predict.sv */
// ------------------------------
// static prediction on the realigned slots
// backward branches taken, jal and c.j always taken
// jalr is never predicted
// ------------------------------
`default_nettype none

module fetch_branch_predict
    import fetch_pkg::*;
    import rv_isa_pkg::*;
(
    input  logic              resp_valid_i,
    input  addr_t             resp_addr_i,
    input  word_t             resp_word_i,
    input  word_t [SLOTS-1:0] instr_i,
    input  addr_t [SLOTS-1:0] instr_addr_i,
    input  logic  [SLOTS-1:0] slot_valid_i,
    output logic              push_o,
    output addr_t             entry_addr_o,
    output word_t             entry_data_o,
    output logic  [SLOTS-1:0] entry_taken_o,
    output addr_t             entry_target_o,
    output logic              pred_valid_o,
    output addr_t             pred_target_o
);

    logic [SLOTS-1:0] taken;
    addr_t            target;

    // ------------------------------
    // instruction scan
    // ------------------------------
    function automatic cf_kind_e scan_kind(word_t ins);
        cf_kind_e kind;
        kind = CF_NONE;
        if (ins[1:0] == 2'b11) begin
            case (ins[6:0])
                OPC_BRANCH: kind = CF_BRANCH;
                OPC_JAL:    kind = CF_JUMP;
                // register target only known in execute
                OPC_JALR:   kind = CF_NONE;
                default:    kind = CF_NONE;
            endcase
        end else if (ins[1:0] == 2'b01) begin
            case (ins[15:13])
                C_J:            kind = CF_JUMP;
                C_BEQZ, C_BNEZ: kind = CF_BRANCH;
                default:        kind = CF_NONE;
            endcase
        end
        return kind;
    endfunction

    // sign-extended offset, only meaningful when scan_kind finds something
    function automatic addr_t scan_imm(word_t ins);
        addr_t imm;
        if (ins[1:0] == 2'b11) begin
            if (ins[6:0] == OPC_JAL) begin
                imm = $signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0});
            end else begin
                imm = $signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0});
            end
        end else if (ins[15:13] == C_J) begin
            imm = $signed({ins[12], ins[8], ins[10:9], ins[6], ins[7], ins[2],
                           ins[11], ins[5:3], 1'b0});
        end else begin
            imm = $signed({ins[12], ins[6:5], ins[2], ins[11:10], ins[4:3], 1'b0});
        end
        return imm;
    endfunction

    // ------------------------------
    // taken decision
    // ------------------------------
    always_comb begin : pick
        cf_kind_e kind;
        addr_t    imm;
        logic     found;
        found  = 1'b0;
        taken  = '0;
        target = '0;
        // lowest address wins, later slots are shadowed
        for (int i = 0; i < SLOTS; i++) begin
            kind = scan_kind(instr_i[i]);
            imm  = scan_imm(instr_i[i]);
            if (slot_valid_i[i] && !found) begin
                // negative offset means backward branch
                if (kind == CF_JUMP || (kind == CF_BRANCH && imm[ADDR_W-1])) begin
                    taken[i] = 1'b1;
                    target   = instr_addr_i[i] + imm;
                    found    = 1'b1;
                end
            end
        end
    end

    assign pred_valid_o  = resp_valid_i & (|taken);
    assign pred_target_o = target;

    // every response becomes one queue entry
    assign push_o         = resp_valid_i;
    assign entry_addr_o   = resp_addr_i;
    assign entry_data_o   = resp_word_i;
    assign entry_taken_o  = taken;
    assign entry_target_o = target;

endmodule : fetch_branch_predict

`default_nettype wire

/* fetch_frontend.sv */
// ------------------------------
// fetch frontend top
// memory answers one cycle after acceptance
// FIFO_DEPTH from 2 to 8
// ------------------------------
`default_nettype none

module fetch_frontend
    import fetch_pkg::*;
#(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  addr_t            boot_addr_i,
    input  logic             redirect_i,
    input  addr_t            redirect_addr_i,
    // memory request
    output logic             mem_req_o,
    output addr_t            mem_addr_o,
    input  logic             mem_ready_i,
    output logic             mem_kill_s1_o,
    output logic             mem_kill_s2_o,
    // memory response
    input  logic             mem_rvalid_i,
    input  addr_t            mem_raddr_i,
    input  word_t            mem_rdata_i,
    // decode side
    output logic             fetch_valid_o,
    output addr_t            fetch_addr_o,
    output word_t            fetch_data_o,
    output logic [SLOTS-1:0] fetch_taken_o,
    output addr_t            fetch_target_o,
    input  logic             fetch_ack_i
);

    logic              pred_valid;
    addr_t             pred_target;
    logic              pop;
    logic              resp_valid;
    addr_t             resp_addr;
    word_t             resp_word;
    word_t [SLOTS-1:0] instr;
    addr_t [SLOTS-1:0] instr_addr;
    logic  [SLOTS-1:0] slot_valid;
    logic              push;
    addr_t             entry_addr;
    word_t             entry_data;
    logic  [SLOTS-1:0] entry_taken;
    addr_t             entry_target;

    fetch_pc_gen #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fetch_pc_gen_i (
        .clk_i,
        .rst_ni,
        .boot_addr_i,
        .redirect_i,
        .redirect_addr_i,
        .pred_valid_i  (pred_valid),
        .pred_target_i (pred_target),
        .pop_i         (pop),
        .mem_ready_i,
        .mem_rvalid_i,
        .mem_req_o,
        .mem_addr_o,
        .mem_kill_s1_o,
        .mem_kill_s2_o
    );

    // kill_s2 covers both redirect and taken prediction
    fetch_realign fetch_realign_i (
        .clk_i,
        .rst_ni,
        .mem_rvalid_i,
        .mem_raddr_i,
        .mem_rdata_i,
        .kill_i       (mem_kill_s2_o),
        .resp_valid_o (resp_valid),
        .resp_addr_o  (resp_addr),
        .resp_word_o  (resp_word),
        .instr_o      (instr),
        .instr_addr_o (instr_addr),
        .slot_valid_o (slot_valid)
    );

    fetch_branch_predict fetch_branch_predict_i (
        .resp_valid_i   (resp_valid),
        .resp_addr_i    (resp_addr),
        .resp_word_i    (resp_word),
        .instr_i        (instr),
        .instr_addr_i   (instr_addr),
        .slot_valid_i   (slot_valid),
        .push_o         (push),
        .entry_addr_o   (entry_addr),
        .entry_data_o   (entry_data),
        .entry_taken_o  (entry_taken),
        .entry_target_o (entry_target),
        .pred_valid_o   (pred_valid),
        .pred_target_o  (pred_target)
    );

    fetch_queue #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fetch_queue_i (
        .clk_i,
        .rst_ni,
        .flush_i  (redirect_i),
        .push_i   (push),
        .addr_i   (entry_addr),
        .data_i   (entry_data),
        .taken_i  (entry_taken),
        .target_i (entry_target),
        .fetch_ack_i,
        .fetch_valid_o,
        .fetch_addr_o,
        .fetch_data_o,
        .fetch_taken_o,
        .fetch_target_o,
        .pop_o    (pop)
    );

endmodule : fetch_frontend

`default_nettype wire

/* fetch_pc_gen.sv */
// ------------------------------
// next-PC select and memory request side
// a request is issued only while queue credits remain
// ------------------------------
`default_nettype none

module fetch_pc_gen
    import fetch_pkg::*;
#(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic  clk_i,
    input  logic  rst_ni,
    input  addr_t boot_addr_i,
    input  logic  redirect_i,
    input  addr_t redirect_addr_i,
    input  logic  pred_valid_i,
    input  addr_t pred_target_i,
    input  logic  pop_i,
    input  logic  mem_ready_i,
    input  logic  mem_rvalid_i,
    output logic  mem_req_o,
    output addr_t mem_addr_o,
    output logic  mem_kill_s1_o,
    output logic  mem_kill_s2_o
);

    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH) + 1;

    logic             npc_rst_load_q;
    addr_t            npc_d;
    addr_t            npc_q;
    addr_t            fetch_addr;
    logic [CNT_W-1:0] credits_d;
    logic [CNT_W-1:0] credits_q;
    logic             in_flight_d;
    logic             in_flight_q;
    logic             if_ready;
    logic             issue;
    logic             eff_kill;

    // ------------------------------
    // next PC
    // ------------------------------
    always_comb begin : npc_select
        // first cycle out of reset fetches from the boot address
        fetch_addr = npc_rst_load_q ? boot_addr_i : npc_q;
        if (pred_valid_i) begin
            fetch_addr = pred_target_i;
        end
        npc_d = fetch_addr;
        // advance to the next aligned word once accepted
        if (if_ready) begin
            npc_d = {fetch_addr[ADDR_W-1:2], 2'b00} + addr_t'(4);
        end
        // redirect overrides everything
        if (redirect_i) begin
            npc_d = redirect_addr_i;
        end
    end

    assign mem_addr_o    = fetch_addr;
    // redirect kills the request in this cycle
    assign mem_kill_s1_o = redirect_i;
    // a taken prediction also drops the word already in flight
    assign mem_kill_s2_o = redirect_i | pred_valid_i;

    // ------------------------------
    // credit flow control
    // ------------------------------
    assign mem_req_o = |credits_q;
    assign if_ready  = mem_ready_i & mem_req_o;
    assign issue     = if_ready & ~mem_kill_s1_o;
    // killed in-flight request never returns, give its credit back
    assign eff_kill  = in_flight_q & mem_kill_s2_o;

    assign credits_d = redirect_i ? CNT_W'(FIFO_DEPTH)
                     : credits_q + CNT_W'(pop_i) + CNT_W'(eff_kill) - CNT_W'(issue);

    assign in_flight_d = redirect_i   ? 1'b0
                       : issue        ? 1'b1
                       : mem_rvalid_i ? 1'b0
                       : in_flight_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_rst_load_q <= 1'b1;
            npc_q          <= '0;
            credits_q      <= CNT_W'(FIFO_DEPTH);
            in_flight_q    <= 1'b0;
        end else begin
            npc_rst_load_q <= 1'b0;
            npc_q          <= npc_d;
            credits_q      <= credits_d;
            in_flight_q    <= in_flight_d;
        end
    end

endmodule : fetch_pc_gen

`default_nettype wire

/* fetch_pkg.sv */
// ------------------------------
// fetch datapath widths for a 64-bit core
// one fetch word is 32 bits and holds at most two 16-bit parcels
// ------------------------------
`default_nettype none

package fetch_pkg;

    // instruction address width
    parameter int unsigned ADDR_W = 64;

    // fetch word width as seen on the memory data port
    parameter int unsigned WORD_W = 32;

    // instruction slots per fetch word, one per parcel
    parameter int unsigned SLOTS = 2;

    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [WORD_W-1:0] word_t;

    // half of a fetch word, the RVC granule
    typedef logic [WORD_W/SLOTS-1:0] parcel_t;

endpackage : fetch_pkg

`default_nettype wire

/* fetch_queue.sv */
// ------------------------------
// fetch entry FIFO toward decode
// no overflow check, credits in pc gen bound the fill level
// ------------------------------
`default_nettype none

module fetch_queue
    import fetch_pkg::*;
#(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             flush_i,
    input  logic             push_i,
    input  addr_t            addr_i,
    input  word_t            data_i,
    input  logic [SLOTS-1:0] taken_i,
    input  addr_t            target_i,
    input  logic             fetch_ack_i,
    output logic             fetch_valid_o,
    output addr_t            fetch_addr_o,
    output word_t            fetch_data_o,
    output logic [SLOTS-1:0] fetch_taken_o,
    output addr_t            fetch_target_o,
    output logic             pop_o
);

    localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
    localparam int unsigned CNT_W = PTR_W + 1;

    addr_t            addr_mem   [FIFO_DEPTH];
    word_t            data_mem   [FIFO_DEPTH];
    logic [SLOTS-1:0] taken_mem  [FIFO_DEPTH];
    addr_t            target_mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    // wrap explicitly, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign fetch_valid_o  = |count_q;
    assign pop_o          = fetch_valid_o & fetch_ack_i;
    assign fetch_addr_o   = addr_mem[rd_ptr_q];
    assign fetch_data_o   = data_mem[rd_ptr_q];
    assign fetch_taken_o  = taken_mem[rd_ptr_q];
    assign fetch_target_o = target_mem[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // drop everything, including a push in this cycle
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop_o) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            count_q <= count_q + CNT_W'(push_i) - CNT_W'(pop_o);
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            addr_mem[wr_ptr_q]   <= addr_i;
            data_mem[wr_ptr_q]   <= data_i;
            taken_mem[wr_ptr_q]  <= taken_i;
            target_mem[wr_ptr_q] <= target_i;
        end
    end

endmodule : fetch_queue

`default_nettype wire

/* fetch_realign.sv */
// ------------------------------
// response register and 16/32-bit realignment
// a 32-bit instruction may straddle two consecutive words
// kill_i drops any half instruction that is waiting
// ------------------------------
`default_nettype none

module fetch_realign
    import fetch_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   mem_rvalid_i,
    input  addr_t                  mem_raddr_i,
    input  word_t                  mem_rdata_i,
    input  logic                   kill_i,
    output logic                   resp_valid_o,
    output addr_t                  resp_addr_o,
    output word_t                  resp_word_o,
    output word_t [SLOTS-1:0]      instr_o,
    output addr_t [SLOTS-1:0]      instr_addr_o,
    output logic  [SLOTS-1:0]      slot_valid_o
);

    logic             valid_q;
    addr_t            addr_q;
    word_t            data_q;
    logic [SLOTS-1:0] is_c;
    parcel_t          lower;
    parcel_t          upper;
    logic             upper_start;

    // upper parcel waiting for the next word
    logic    unaligned_d;
    logic    unaligned_q;
    parcel_t unaligned_instr_d;
    parcel_t unaligned_instr_q;
    addr_t   unaligned_addr_d;
    addr_t   unaligned_addr_q;

    assign lower = data_q[WORD_W/2-1:0];
    assign upper = data_q[WORD_W-1:WORD_W/2];

    // a parcel is compressed unless its low bits are 2'b11
    for (genvar i = 0; i < SLOTS; i++) begin : g_rvc
        assign is_c[i] = ~&data_q[i*16 +: 2];
    end

    // upper parcel starts an instruction
    assign upper_start = unaligned_q | addr_q[1] | is_c[0];

    always_comb begin : re_align
        unaligned_d       = unaligned_q;
        unaligned_instr_d = unaligned_instr_q;
        unaligned_addr_d  = unaligned_addr_q;
        instr_o[0]        = data_q;
        instr_addr_o[0]   = {addr_q[ADDR_W-1:2], 2'b00};
        instr_o[1]        = word_t'(upper);
        instr_addr_o[1]   = {addr_q[ADDR_W-1:2], 2'b10};
        slot_valid_o      = '0;

        if (valid_q) begin
            // stitch the saved parcel below the lower half
            if (unaligned_q) begin
                instr_o[0]      = {lower, unaligned_instr_q};
                instr_addr_o[0] = unaligned_addr_q;
            end
            // fetch started at a half-word, lower slot is stale
            slot_valid_o[0] = unaligned_q | ~addr_q[1];
            unaligned_d     = 1'b0;
            if (upper_start) begin
                if (is_c[1]) begin
                    slot_valid_o[1] = 1'b1;
                end else begin
                    // 32-bit instruction continues in the next word
                    unaligned_d       = 1'b1;
                    unaligned_instr_d = upper;
                    unaligned_addr_d  = {addr_q[ADDR_W-1:2], 2'b10};
                end
            end
        end

        // next word is not sequential, start clean
        if (kill_i) begin
            unaligned_d = 1'b0;
        end
    end

    assign resp_valid_o = valid_q;
    assign resp_addr_o  = addr_q;
    assign resp_word_o  = data_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q     <= 1'b0;
            unaligned_q <= 1'b0;
        end else begin
            valid_q     <= mem_rvalid_i;
            unaligned_q <= unaligned_d;
        end
    end

    // payload
    always_ff @(posedge clk_i) begin
        addr_q            <= mem_raddr_i;
        data_q            <= mem_rdata_i;
        unaligned_instr_q <= unaligned_instr_d;
        unaligned_addr_q  <= unaligned_addr_d;
    end

endmodule : fetch_realign

`default_nettype wire

/* rv_isa_pkg.sv */
// ------------------------------
// RISC-V encodings seen by the fetch scan
// only control-flow opcodes are listed
// ------------------------------
`default_nettype none

package rv_isa_pkg;

    // major opcodes of 32-bit instructions, bits [6:0]
    typedef enum logic [6:0] {
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } rv_opcode_e;

    // quadrant 1 funct3, bits [15:13] of a compressed instruction
    // RV64 has no C.JAL, 3'b001 is C.ADDIW there
    typedef enum logic [2:0] {
        C_J    = 3'b101,
        C_BEQZ = 3'b110,
        C_BNEZ = 3'b111
    } rvc_op_e;

    // what the scan found in one slot
    typedef enum logic [1:0] {
        CF_NONE   = 2'd0,
        CF_BRANCH = 2'd1,
        CF_JUMP   = 2'd2
    } cf_kind_e;

endpackage : rv_isa_pkg

`default_nettype wire

/* src.f */
fetch_pkg.sv
rv_isa_pkg.sv
fetch_pc_gen.sv
fetch_realign.sv
fetch_branch_predict.sv
fetch_queue.sv
fetch_frontend.sv
tb_fetch_frontend.sv

/* tb_fetch_frontend.sv */
// ------------------------------
// testbench for the fetch frontend, FIFO_DEPTH 4
// memory is always ready and answers one cycle after acceptance
// one table row per scenario, each row after the first starts with a redirect
// ------------------------------
`default_nettype none

module tb_fetch_frontend
    import fetch_pkg::*;
();

    localparam int NROWS     = 6;
    localparam int MAXE      = 8;
    localparam int DEPTH     = 4;
    // cycles allowed for one row before the run is declared hung
    localparam int ROW_LIMIT = 200;

    logic             clk_i;
    logic             rst_ni;
    addr_t            boot_addr_i;
    logic             redirect_i;
    addr_t            redirect_addr_i;
    logic             mem_req_o;
    addr_t            mem_addr_o;
    logic             mem_ready_i;
    logic             mem_kill_s1_o;
    logic             mem_kill_s2_o;
    logic             mem_rvalid_i;
    addr_t            mem_raddr_i;
    word_t            mem_rdata_i;
    logic             fetch_valid_o;
    addr_t            fetch_addr_o;
    word_t            fetch_data_o;
    logic [SLOTS-1:0] fetch_taken_o;
    addr_t            fetch_target_o;
    logic             fetch_ack_i;

    // ------------------------------
    // scenario table
    // ------------------------------
    addr_t      row_start  [NROWS];
    logic       row_redir  [NROWS];
    logic       row_rand   [NROWS];
    int         row_len    [NROWS];
    addr_t      exp_addr   [NROWS][MAXE];
    logic [1:0] exp_taken  [NROWS][MAXE];
    addr_t      exp_target [NROWS][MAXE];

    // special words of the image, everything else is filler
    word_t image [addr_t];

    // memory model and bookkeeping
    logic        pend;
    addr_t       pend_addr;
    int          outstanding;
    logic        first_req;
    logic [31:0] lfsr;

    fetch_frontend #(
        .FIFO_DEPTH (DEPTH)
    ) fetch_frontend_i (
        .clk_i,
        .rst_ni,
        .boot_addr_i,
        .redirect_i,
        .redirect_addr_i,
        .mem_req_o,
        .mem_addr_o,
        .mem_ready_i,
        .mem_kill_s1_o,
        .mem_kill_s2_o,
        .mem_rvalid_i,
        .mem_raddr_i,
        .mem_rdata_i,
        .fetch_valid_o,
        .fetch_addr_o,
        .fetch_data_o,
        .fetch_taken_o,
        .fetch_target_o,
        .fetch_ack_i
    );

    initial begin
        clk_i = 1'b0;
    end

    always #20 clk_i = ~clk_i;

    // fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // filler is an OP-IMM word whose upper bits fold the whole address
    function automatic word_t mem_word(input addr_t a);
        addr_t       al;
        logic [31:0] h;
        al = {a[ADDR_W-1:2], 2'b00};
        h  = al[63:32] ^ al[31:0];
        if (image.exists(al)) begin
            return image[al];
        end
        return {h[31:7] ^ {h[6:0], 18'b0}, 7'b0010011};
    endfunction

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic set_entry(input int r, input int e, input addr_t a,
                             input logic [1:0] t, input addr_t tgt);
        exp_addr[r][e]   = a;
        exp_taken[r][e]  = t;
        exp_target[r][e] = tgt;
        if (e + 1 > row_len[r]) begin
            row_len[r] = e + 1;
        end
    endtask

    task automatic set_row(input int r, input addr_t a, input logic redir, input logic rnd);
        row_start[r] = a;
        row_redir[r] = redir;
        row_rand[r]  = rnd;
        row_len[r]   = 0;
    endtask

    task automatic load_table();
        // ------------------------------
        // memory image
        // ------------------------------
        // beq x0,x0,-16 loops back to 0x1000
        image[64'h1010] = 32'hfe0008e3;
        // forward beq +8, then jal +0x100
        image[64'h2000] = 32'h00000463;
        image[64'h2004] = 32'h1000006f;
        // c.nop low, c.beqz -6 high
        image[64'h2104] = 32'hdc6d0001;
        // c.j +0x10 low shadows a backward c.beqz high
        image[64'h3000] = 32'hdc6da801;
        // beq -18 at 0x3012 straddles into the next word
        image[64'h3010] = 32'h07e30001;
        image[64'h3014] = 32'h0001fe00;
        // backward c.beqz sits below a half-word redirect target
        image[64'h4000] = 32'h0001dc6d;

        // boot, sequential words then a backward branch
        set_row(0, 64'h1000, 1'b0, 1'b0);
        set_entry(0, 0, 64'h1000, 2'b00, 64'h0);
        set_entry(0, 1, 64'h1004, 2'b00, 64'h0);
        set_entry(0, 2, 64'h1008, 2'b00, 64'h0);
        set_entry(0, 3, 64'h100c, 2'b00, 64'h0);
        set_entry(0, 4, 64'h1010, 2'b01, 64'h1000);
        set_entry(0, 5, 64'h1000, 2'b00, 64'h0);
        // forward branch, jal, compressed backward branch in slot 1
        set_row(1, 64'h2000, 1'b1, 1'b0);
        set_entry(1, 0, 64'h2000, 2'b00, 64'h0);
        set_entry(1, 1, 64'h2004, 2'b01, 64'h2104);
        set_entry(1, 2, 64'h2104, 2'b10, 64'h2100);
        set_entry(1, 3, 64'h2100, 2'b00, 64'h0);
        set_entry(1, 4, 64'h2104, 2'b10, 64'h2100);
        // c.j shadowing slot 1, then the straddling branch
        set_row(2, 64'h3000, 1'b1, 1'b0);
        set_entry(2, 0, 64'h3000, 2'b01, 64'h3010);
        set_entry(2, 1, 64'h3010, 2'b00, 64'h0);
        set_entry(2, 2, 64'h3014, 2'b01, 64'h3000);
        set_entry(2, 3, 64'h3000, 2'b01, 64'h3010);
        // half-word start, slot 0 must stay clear
        set_row(3, 64'h4002, 1'b1, 1'b0);
        set_entry(3, 0, 64'h4002, 2'b00, 64'h0);
        set_entry(3, 1, 64'h4004, 2'b00, 64'h0);
        set_entry(3, 2, 64'h4008, 2'b00, 64'h0);
        // rows 0 and 1 again with gaps in the ack
        set_row(4, 64'h1000, 1'b1, 1'b1);
        for (int e = 0; e < 6; e++) begin
            set_entry(4, e, exp_addr[0][e], exp_taken[0][e], exp_target[0][e]);
        end
        set_entry(4, 6, 64'h1004, 2'b00, 64'h0);
        set_entry(4, 7, 64'h1008, 2'b00, 64'h0);
        set_row(5, 64'h2000, 1'b1, 1'b1);
        for (int e = 0; e < 5; e++) begin
            set_entry(5, e, exp_addr[1][e], exp_taken[1][e], exp_target[1][e]);
        end
    endtask

    // ------------------------------
    // one scenario, entered 5 units after a rising edge
    // ------------------------------
    task automatic run_row(input int r);
        int   cyc;
        int   got;
        logic redir_now;
        cyc = 0;
        got = 0;
        while (got < row_len[r]) begin
            if (cyc >= ROW_LIMIT) begin
                $display("timeout: row %0d gave %0d of %0d entries", r, got, row_len[r]);
                $display(">>> FAIL");
                $fatal(1, "no progress from the DUT");
            end
            redir_now       = row_redir[r] && (cyc == 0);
            redirect_i      = redir_now;
            redirect_addr_i = row_start[r];
            // decode stays idle in the redirect cycle
            if (redir_now) begin
                fetch_ack_i = 1'b0;
                pend        = 1'b0;
                outstanding = 0;
            end else if (row_rand[r]) begin
                lfsr        = lfsr_next(lfsr);
                fetch_ack_i = lfsr[0];
            end else begin
                fetch_ack_i = 1'b1;
            end
            #1;
            // answer last cycle's request unless it was killed
            mem_rvalid_i = 1'b0;
            if (pend && !mem_kill_s2_o) begin
                mem_rvalid_i = 1'b1;
                mem_raddr_i  = {pend_addr[ADDR_W-1:1], 1'b0};
                mem_rdata_i  = mem_word(pend_addr);
            end else if (pend) begin
                outstanding--;
            end
            pend = 1'b0;

            @(negedge clk_i);
            if (mem_req_o && mem_ready_i && !mem_kill_s1_o) begin
                if (first_req) begin
                    check(mem_addr_o, boot_addr_i, "first request address");
                    first_req = 1'b0;
                end
                pend      = 1'b1;
                pend_addr = mem_addr_o;
                outstanding++;
            end
            if (fetch_valid_o && fetch_ack_i) begin
                check(fetch_addr_o, exp_addr[r][got], "entry address");
                check(64'(fetch_data_o), 64'(mem_word(exp_addr[r][got])), "entry data");
                check(64'(fetch_taken_o), 64'(exp_taken[r][got]), "entry taken bits");
                if (exp_taken[r][got] != 2'b00) begin
                    check(fetch_target_o, exp_target[r][got], "entry target");
                end
                got++;
                outstanding--;
            end
            if (outstanding > DEPTH) begin
                $display("more than %0d entries pending in row %0d", DEPTH, r);
                $display(">>> FAIL");
                $fatal(1, "credit bound broken");
            end
            @(posedge clk_i);
            #5;
            cyc++;
        end
    endtask

    initial begin
        rst_ni          = 1'b0;
        redirect_i      = 1'b0;
        redirect_addr_i = '0;
        mem_ready_i     = 1'b1;
        mem_rvalid_i    = 1'b0;
        mem_raddr_i     = '0;
        mem_rdata_i     = '0;
        fetch_ack_i     = 1'b0;
        pend            = 1'b0;
        pend_addr       = '0;
        outstanding     = 0;
        first_req       = 1'b1;
        lfsr            = 32'hb4e9_2a80;
        load_table();
        boot_addr_i = row_start[0];

        repeat (5) @(posedge clk_i);
        #5;
        rst_ni = 1'b1;

        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule : tb_fetch_frontend

`default_nettype wire
